/* logic/scope_pkg.sv */
`default_nettype none

package scope_pkg;

    // One sample fills exactly one memory word
    localparam int sample_width = 32;

    typedef logic [sample_width-1:0] sample_t;

    // Byte addresses on the memory write port
    localparam int addr_width = 32;

    typedef logic [addr_width-1:0] addr_t;

    // Width of the pre-trigger sample count
    localparam int point_width = 16;

    // Address step between consecutive words of a record
    localparam addr_t word_bytes = addr_t'(sample_width / 8);

    // Defaults for the top-level sizing parameters
    localparam int default_channel_samples = 64;
    localparam int default_n_channels = 4;
    localparam int default_max_credits = 8;

endpackage

`default_nettype wire

/* logic/scope_trigger.sv */
`timescale 1ns/1ns
`default_nettype none

module scope_trigger (
    input wire clock,
    input wire arst_n,
    input wire arm,
    input wire sample_valid,
    input wire scope_pkg::sample_t ch0_sample,
    input wire scope_pkg::sample_t trigger_level,
    input wire [scope_pkg::point_width-1:0] trigger_point,
    input wire dma_done,
    output logic capture_enable,
    output logic trigger
);

    logic fired;
    logic [scope_pkg::point_width-1:0] pre_count;
    scope_pkg::sample_t prev_ch0;
    logic eligible;
    logic crossing;

    // Enough history is stored once the count reaches the pre-trigger length
    assign eligible = pre_count >= trigger_point;

    // Rising crossing of the level, judged against the last accepted sample
    assign crossing = (ch0_sample >= trigger_level) && (prev_ch0 < trigger_level);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            capture_enable <= 1'b0;
            fired <= 1'b0;
            pre_count <= '0;
            trigger <= 1'b0;
        end else begin
            trigger <= 1'b0;
            if (dma_done) begin
                // End of record, wait for the next arm
                capture_enable <= 1'b0;
            end else if (arm && !capture_enable) begin
                capture_enable <= 1'b1;
                fired <= 1'b0;
                pre_count <= '0;
            end else if (capture_enable && sample_valid && !fired) begin
                if (eligible && crossing) begin
                    trigger <= 1'b1;
                    fired <= 1'b1;
                end else if (!eligible) begin
                    pre_count <= pre_count + 1'b1;
                end
            end
        end
    end

    // The previous channel 0 sample is tracked whether armed or not
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            prev_ch0 <= '0;
        end else if (sample_valid) begin
            prev_ch0 <= ch0_sample;
        end
    end

endmodule

`default_nettype wire

/* logic/scope_capture_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module scope_capture_buffer #(
    parameter int CHANNEL_SAMPLES = scope_pkg::default_channel_samples
) (
    input wire clock,
    input wire arst_n,
    input wire capture_enable,
    input wire trigger,
    input wire [scope_pkg::point_width-1:0] trigger_point,
    input wire sample_valid,
    input wire scope_pkg::sample_t sample,
    input wire dma_done,
    input wire rd_select,
    input wire [$clog2(CHANNEL_SAMPLES)-1:0] rd_addr,
    output logic full,
    output scope_pkg::sample_t rd_data
);

    localparam int AW = $clog2(CHANNEL_SAMPLES);
    localparam int CW = AW + 1;

    scope_pkg::sample_t mem [CHANNEL_SAMPLES];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic triggered;
    logic [CW-1:0] post_count;
    logic [CW-1:0] post_target;
    logic [CW-1:0] post_base;
    logic [CW-1:0] post_next;
    logic accept;

    // Samples still needed after the trigger to complete the record
    assign post_target = CW'(CHANNEL_SAMPLES) - CW'(trigger_point);

    // The triggering sample was stored the cycle before the trigger pulse,
    // so it is already counted when the pulse arrives
    assign post_base = trigger ? CW'(1) : post_count;

    // A record of one post-trigger sample is complete on the pulse itself
    assign accept = sample_valid && capture_enable && !full
        && !(trigger && post_target == CW'(1));

    assign post_next = post_base + CW'(accept);

    // Once full the pointer is frozen and sits on the oldest sample
    assign rd_ptr = wr_ptr + rd_addr;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            triggered <= 1'b0;
            post_count <= '0;
            full <= 1'b0;
        end else begin
            if (accept) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (dma_done) begin
                triggered <= 1'b0;
                post_count <= '0;
                full <= 1'b0;
            end else if (trigger || triggered) begin
                triggered <= 1'b1;
                post_count <= post_next;
                if (post_next == post_target) begin
                    full <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            mem[wr_ptr] <= sample;
        end
        if (rd_select) begin
            rd_data <= mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

/* logic/scope_serializer.sv */
`timescale 1ns/1ns
`default_nettype none

module scope_serializer #(
    parameter int N_CHANNELS = scope_pkg::default_n_channels,
    parameter int CHANNEL_SAMPLES = scope_pkg::default_channel_samples
) (
    input wire clock,
    input wire arst_n,
    input wire [N_CHANNELS-1:0] buffer_full,
    input wire scope_pkg::sample_t [N_CHANNELS-1:0] rd_data,
    input wire ser_ready,
    input wire dma_done,
    output logic [N_CHANNELS-1:0] rd_select,
    output logic [$clog2(CHANNEL_SAMPLES)-1:0] rd_addr,
    output logic ser_valid,
    output scope_pkg::sample_t ser_data
);

    localparam int AW = $clog2(CHANNEL_SAMPLES);
    localparam int CH_W = (N_CHANNELS > 1) ? $clog2(N_CHANNELS) : 1;

    logic [CH_W-1:0] ch;
    logic [AW-1:0] idx;
    logic issue_done;

    // Read issued last cycle, its data is on rd_data now
    logic pend;
    logic [CH_W-1:0] pend_ch;

    // Two-entry output queue, head at entry 0
    scope_pkg::sample_t q_data [2];
    logic [1:0] q_count;

    logic pop;
    logic [2:0] occ_next;
    logic issue;

    assign pop = ser_valid && ser_ready;

    // Queue occupancy at the end of this cycle
    assign occ_next = {1'b0, q_count} + {2'b00, pend} - {2'b00, pop};

    // A new read lands next cycle, so it must find a free entry then
    assign issue = (&buffer_full) && !issue_done && (occ_next <= 3'd1);

    assign rd_select = issue ? (N_CHANNELS'(1) << ch) : '0;
    assign rd_addr = idx;

    assign ser_valid = q_count != 2'd0;
    assign ser_data = q_data[0];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ch <= '0;
            idx <= '0;
            issue_done <= 1'b0;
            pend <= 1'b0;
            pend_ch <= '0;
            q_count <= '0;
        end else if (dma_done) begin
            ch <= '0;
            idx <= '0;
            issue_done <= 1'b0;
            pend <= 1'b0;
            pend_ch <= '0;
            q_count <= '0;
        end else begin
            pend <= issue;
            pend_ch <= ch;
            q_count <= occ_next[1:0];
            if (issue) begin
                if (&idx) begin
                    idx <= '0;
                    if (ch == CH_W'(N_CHANNELS - 1)) begin
                        issue_done <= 1'b1;
                    end else begin
                        ch <= ch + 1'b1;
                    end
                end else begin
                    idx <= idx + 1'b1;
                end
            end
        end
    end

    // On a simultaneous pop the incoming word goes one slot lower
    always_ff @(posedge clock) begin
        if (pop) begin
            q_data[0] <= q_data[1];
        end
        if (pend) begin
            if (pop) begin
                q_data[q_count == 2'd2] <= rd_data[pend_ch];
            end else begin
                q_data[q_count != 2'd0] <= rd_data[pend_ch];
            end
        end
    end

endmodule

`default_nettype wire

/* logic/scope_dma_writer.sv */
`timescale 1ns/1ns
`default_nettype none

module scope_dma_writer #(
    parameter int MAX_CREDITS = scope_pkg::default_max_credits,
    parameter int N_CHANNELS = scope_pkg::default_n_channels,
    parameter int CHANNEL_SAMPLES = scope_pkg::default_channel_samples
) (
    input wire clock,
    input wire arst_n,
    input wire scope_pkg::addr_t base_addr,
    input wire ser_valid,
    input wire scope_pkg::sample_t ser_data,
    input wire credit_return,
    output logic ser_ready,
    output logic wr_valid,
    output scope_pkg::addr_t wr_addr,
    output scope_pkg::sample_t wr_data,
    output logic dma_done
);

    localparam int TOTAL = N_CHANNELS * CHANNEL_SAMPLES;
    localparam int IW = $clog2(TOTAL);
    localparam int CRW = $clog2(MAX_CREDITS + 1);

    logic [CRW-1:0] credits;
    logic [IW-1:0] word_idx;
    logic accept;
    logic last_word;
    logic wr_last;

    // The credit is spent on acceptance, the beat follows one cycle later
    assign ser_ready = credits != '0;
    assign accept = ser_valid && ser_ready;
    assign last_word = word_idx == IW'(TOTAL - 1);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            credits <= CRW'(MAX_CREDITS);
            word_idx <= '0;
            wr_valid <= 1'b0;
            wr_last <= 1'b0;
            dma_done <= 1'b0;
        end else begin
            wr_valid <= accept;
            wr_last <= accept && last_word;
            dma_done <= wr_last;

            // A beat and a return in the same cycle cancel out
            if (accept && !credit_return) begin
                credits <= credits - 1'b1;
            end else if (!accept && credit_return) begin
                credits <= credits + 1'b1;
            end

            if (accept) begin
                word_idx <= last_word ? '0 : word_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            wr_data <= ser_data;
            wr_addr <= base_addr + scope_pkg::addr_t'(word_idx) * scope_pkg::word_bytes;
        end
    end

endmodule

`default_nettype wire

/* logic/scope_top.sv */
`timescale 1ns/1ns
`default_nettype none

module scope_top #(
    parameter int N_CHANNELS = scope_pkg::default_n_channels,
    parameter int CHANNEL_SAMPLES = scope_pkg::default_channel_samples,
    parameter int MAX_CREDITS = scope_pkg::default_max_credits
) (
    input wire clock,
    input wire arst_n,
    input wire sample_valid,
    input wire scope_pkg::sample_t [N_CHANNELS-1:0] sample_data,
    input wire scope_pkg::sample_t trigger_level,
    input wire [scope_pkg::point_width-1:0] trigger_point,
    input wire scope_pkg::addr_t base_addr,
    input wire arm,
    output wire wr_valid,
    output wire scope_pkg::addr_t wr_addr,
    output wire scope_pkg::sample_t wr_data,
    input wire credit_return,
    output wire dma_done
);

    localparam int AW = $clog2(CHANNEL_SAMPLES);

    wire capture_enable;
    wire trigger;
    wire [N_CHANNELS-1:0] buffer_full;
    wire [N_CHANNELS-1:0] rd_select;
    wire [AW-1:0] rd_addr;
    wire scope_pkg::sample_t [N_CHANNELS-1:0] rd_data;
    wire ser_valid;
    wire ser_ready;
    wire scope_pkg::sample_t ser_data;

    // Channel 0 is the trigger source
    scope_trigger trigger_unit (
        .clock(clock),
        .arst_n(arst_n),
        .arm(arm),
        .sample_valid(sample_valid),
        .ch0_sample(sample_data[0]),
        .trigger_level(trigger_level),
        .trigger_point(trigger_point),
        .dma_done(dma_done),
        .capture_enable(capture_enable),
        .trigger(trigger)
    );

    for (genvar i = 0; i < N_CHANNELS; i++) begin : gen_buffer
        scope_capture_buffer #(
            .CHANNEL_SAMPLES(CHANNEL_SAMPLES)
        ) buffer (
            .clock(clock),
            .arst_n(arst_n),
            .capture_enable(capture_enable),
            .trigger(trigger),
            .trigger_point(trigger_point),
            .sample_valid(sample_valid),
            .sample(sample_data[i]),
            .dma_done(dma_done),
            .rd_select(rd_select[i]),
            .rd_addr(rd_addr),
            .full(buffer_full[i]),
            .rd_data(rd_data[i])
        );
    end

    scope_serializer #(
        .N_CHANNELS(N_CHANNELS),
        .CHANNEL_SAMPLES(CHANNEL_SAMPLES)
    ) serializer (
        .clock(clock),
        .arst_n(arst_n),
        .buffer_full(buffer_full),
        .rd_data(rd_data),
        .ser_ready(ser_ready),
        .dma_done(dma_done),
        .rd_select(rd_select),
        .rd_addr(rd_addr),
        .ser_valid(ser_valid),
        .ser_data(ser_data)
    );

    scope_dma_writer #(
        .MAX_CREDITS(MAX_CREDITS),
        .N_CHANNELS(N_CHANNELS),
        .CHANNEL_SAMPLES(CHANNEL_SAMPLES)
    ) dma_writer (
        .clock(clock),
        .arst_n(arst_n),
        .base_addr(base_addr),
        .ser_valid(ser_valid),
        .ser_data(ser_data),
        .credit_return(credit_return),
        .ser_ready(ser_ready),
        .wr_valid(wr_valid),
        .wr_addr(wr_addr),
        .wr_data(wr_data),
        .dma_done(dma_done)
    );

endmodule

`default_nettype wire

/* sim/scope_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module scope_checker #(
    parameter int N_CHANNELS = scope_pkg::default_n_channels,
    parameter int CHANNEL_SAMPLES = scope_pkg::default_channel_samples,
    parameter int MAX_CREDITS = scope_pkg::default_max_credits
) (
    input wire clock,
    input wire arst_n,
    input wire sample_valid,
    input wire scope_pkg::sample_t [N_CHANNELS-1:0] sample_data,
    input wire scope_pkg::sample_t trigger_level,
    input wire [scope_pkg::point_width-1:0] trigger_point,
    input wire scope_pkg::addr_t base_addr,
    input wire arm,
    input wire wr_valid,
    input wire scope_pkg::addr_t wr_addr,
    input wire scope_pkg::sample_t wr_data,
    input wire credit_return,
    input wire dma_done,
    output int error_count,
    output int records_done
);

    localparam int TOTAL = N_CHANNELS * CHANNEL_SAMPLES;

    logic enabled;
    logic fired;
    logic full;
    logic record_ready;
    logic done_due;
    logic next_due;
    int pre_count;
    int post_count;
    int beat_count;
    int outstanding;
    int point;
    scope_pkg::sample_t level;
    scope_pkg::sample_t prev_ch0;
    scope_pkg::sample_t trig_sample;
    scope_pkg::sample_t record [TOTAL];
    scope_pkg::addr_t base;

    // Last CHANNEL_SAMPLES accepted sample vectors, oldest first
    scope_pkg::sample_t [N_CHANNELS-1:0] hist [$];

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    // Model of one accepted sample, following the trigger and capture rules
    task automatic take_sample();
        hist.push_back(sample_data);
        if (hist.size() > CHANNEL_SAMPLES) begin
            hist.delete(0);
        end
        if (!fired) begin
            if (pre_count >= point && sample_data[0] >= level && prev_ch0 < level) begin
                fired = 1'b1;
                trig_sample = sample_data[0];
                post_count = 1;
            end else if (pre_count < point) begin
                pre_count++;
            end
        end else begin
            post_count++;
        end
        if (fired && post_count == CHANNEL_SAMPLES - point) begin
            full = 1'b1;
            record_ready = 1'b1;
            beat_count = 0;
            for (int c = 0; c < N_CHANNELS; c++) begin
                for (int p = 0; p < CHANNEL_SAMPLES; p++) begin
                    record[c * CHANNEL_SAMPLES + p] = hist[p][c];
                end
            end
        end
    endtask

    task automatic check_beat();
        string name;
        scope_pkg::addr_t exp_addr;
        if (!record_ready) begin
            $display("write beat at address %h arrived with no full record in the model",
                     wr_addr);
            error_count++;
        end else begin
            name = $sformatf("record %0d word %0d", records_done, beat_count);
            if (beat_count == point) begin
                compare({name, " trigger sample"}, trig_sample, wr_data);
            end
            exp_addr = base + scope_pkg::addr_t'(beat_count) * scope_pkg::word_bytes;
            compare({name, " data"}, record[beat_count], wr_data);
            compare({name, " address"}, exp_addr, wr_addr);
            beat_count++;
            if (beat_count == TOTAL) begin
                record_ready = 1'b0;
                next_due = 1'b1;
            end
        end
    endtask

    always @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            enabled = 1'b0;
            fired = 1'b0;
            full = 1'b0;
            record_ready = 1'b0;
            done_due = 1'b0;
            pre_count = 0;
            post_count = 0;
            beat_count = 0;
            outstanding = 0;
            point = 0;
            level = '0;
            prev_ch0 = '0;
            base = '0;
            error_count = 0;
            records_done = 0;
            hist.delete();
        end else begin
            next_due = 1'b0;
            outstanding += int'(wr_valid) - int'(credit_return);
            if (outstanding > MAX_CREDITS) begin
                $display("credit limit broken: %0d beats outstanding", outstanding);
                error_count++;
            end
            compare($sformatf("record %0d dma_done", records_done), 32'(done_due),
                    32'(dma_done));
            if (wr_valid) begin
                check_beat();
            end
            if (sample_valid) begin
                if (enabled && !full) begin
                    take_sample();
                end
                prev_ch0 = sample_data[0];
            end
            if (done_due) begin
                enabled = 1'b0;
                full = 1'b0;
                records_done++;
            end else if (arm && !enabled) begin
                enabled = 1'b1;
                fired = 1'b0;
                full = 1'b0;
                pre_count = 0;
                post_count = 0;
                point = trigger_point;
                level = trigger_level;
                base = base_addr;
                hist.delete();
            end
            done_due = next_due;
        end
    end

endmodule

`default_nettype wire

/* sim/scope_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module scope_tb;

    localparam int N_CHANNELS = 4;
    localparam int CHANNEL_SAMPLES = 16;
    localparam int MAX_CREDITS = 4;
    localparam int RECORDS = 6;
    localparam int DONE_TIMEOUT = 20000;

    logic clock;
    logic arst_n;
    logic sample_valid;
    scope_pkg::sample_t [N_CHANNELS-1:0] sample_data;
    scope_pkg::sample_t trigger_level;
    logic [scope_pkg::point_width-1:0] trigger_point;
    scope_pkg::addr_t base_addr;
    logic arm;
    logic credit_return;
    wire wr_valid;
    wire scope_pkg::addr_t wr_addr;
    wire scope_pkg::sample_t wr_data;
    wire dma_done;
    int checker_errors;
    int records_done;

    int seed = 32'hc8e63533;
    int tb_errors;
    int beats_received;
    int credits_returned;
    int hold;
    logic timed_out;
    logic streaming;

    scope_top #(
        .N_CHANNELS(N_CHANNELS),
        .CHANNEL_SAMPLES(CHANNEL_SAMPLES),
        .MAX_CREDITS(MAX_CREDITS)
    ) uut (
        .clock(clock), .arst_n(arst_n), .sample_valid(sample_valid),
        .sample_data(sample_data), .trigger_level(trigger_level),
        .trigger_point(trigger_point), .base_addr(base_addr), .arm(arm),
        .wr_valid(wr_valid), .wr_addr(wr_addr), .wr_data(wr_data),
        .credit_return(credit_return), .dma_done(dma_done)
    );

    scope_checker #(
        .N_CHANNELS(N_CHANNELS),
        .CHANNEL_SAMPLES(CHANNEL_SAMPLES),
        .MAX_CREDITS(MAX_CREDITS)
    ) scoreboard (
        .clock(clock), .arst_n(arst_n), .sample_valid(sample_valid),
        .sample_data(sample_data), .trigger_level(trigger_level),
        .trigger_point(trigger_point), .base_addr(base_addr), .arm(arm),
        .wr_valid(wr_valid), .wr_addr(wr_addr), .wr_data(wr_data),
        .credit_return(credit_return), .dma_done(dma_done),
        .error_count(checker_errors), .records_done(records_done)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // Memory side counts every beat
    always @(posedge clock) begin
        if (arst_n && wr_valid) begin
            beats_received++;
        end
    end

    // Samples with random gaps, and credits returned after random delays
    // with occasional long hold-off stretches
    always @(negedge clock) begin
        if (streaming) begin
            sample_valid = ($random(seed) & 3) != 0;
            for (int c = 0; c < N_CHANNELS; c++) begin
                sample_data[c] = $random(seed);
            end
            credit_return = 1'b0;
            if (hold > 0) begin
                hold--;
            end else if (($random(seed) & 63) == 0) begin
                hold = 30 + ($random(seed) & 31);
            end else if (beats_received > credits_returned && ($random(seed) & 1)) begin
                credit_return = 1'b1;
                credits_returned++;
            end
        end
    end

    task automatic wait_for_done(input int rec);
        int cycles;
        cycles = 0;
        while (!dma_done && cycles < DONE_TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        if (!dma_done) begin
            $display("timeout: dma_done for record %0d never arrived", rec);
            tb_errors++;
            timed_out = 1'b1;
        end
    endtask

    initial begin
        int point;
        int gap;
        scope_pkg::sample_t level;
        scope_pkg::addr_t base;
        arst_n = 1'b0;
        sample_valid = 1'b0;
        sample_data = '0;
        trigger_level = '0;
        trigger_point = '0;
        base_addr = '0;
        arm = 1'b0;
        credit_return = 1'b0;
        tb_errors = 0;
        beats_received = 0;
        credits_returned = 0;
        hold = 0;
        timed_out = 1'b0;
        streaming = 1'b0;
        repeat (16) @(posedge clock);
        // Random samples start on the same falling edge that releases reset
        streaming = 1'b1;
        @(negedge clock);
        arst_n = 1'b1;
        // Samples stream with no arm, so the memory port must stay quiet
        repeat (60) @(negedge clock);
        for (int rec = 0; rec < RECORDS && !timed_out; rec++) begin
            @(posedge clock);
            point = 1 + (($random(seed) & 32'h7fff_ffff) % (CHANNEL_SAMPLES - 2));
            level = 32'h4000_0000 + ($random(seed) & 32'h7fff_ffff);
            base = $random(seed) & 32'hffff_fffc;
            gap = 5 + ($random(seed) & 15);
            @(negedge clock);
            trigger_point = point[scope_pkg::point_width-1:0];
            trigger_level = level;
            base_addr = base;
            arm = 1'b1;
            @(negedge clock);
            arm = 1'b0;
            // A second arm while the record is under way must be ignored
            repeat (gap) @(negedge clock);
            arm = 1'b1;
            @(negedge clock);
            arm = 1'b0;
            wait_for_done(rec);
            @(negedge clock);
        end
        repeat (20) @(negedge clock);
        if (!timed_out && records_done != RECORDS) begin
            $display("expected %0d records but the checker counted %0d", RECORDS, records_done);
            tb_errors++;
        end
        $display("errors: checker %0d, testbench %0d", checker_errors, tb_errors);
        if (checker_errors == 0 && tb_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
logic/scope_pkg.sv
logic/scope_trigger.sv
logic/scope_capture_buffer.sv
logic/scope_serializer.sv
logic/scope_dma_writer.sv
logic/scope_top.sv
sim/scope_checker.sv
sim/scope_tb.sv
